// File: sources.f
+incdir+verilog
verilog/acq_bus_pkg.sv
verilog/acq_data_pkg.sv
verilog/acq_bus_port.sv
verilog/acq_ctrl_regs.sv
verilog/viz_ctrl.sv
verilog/raw_prefetch.sv
verilog/acq_top.sv
verification/acq_top_props.sv
verification/acq_top_tb.sv

// File: Makefile
TOP := acq_top_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: verification/acq_top_tb.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module acq_top_tb;

   // ------------------------------
   // Table format
   // ------------------------------
   typedef enum {OP_WR, OP_RD, OP_OVF, OP_STRM, OP_WAIT, OP_CHK} op_e;

   // Output selectors for OP_CHK, carried in the address field
   localparam logic [3:0] CHK_VX_EN  = 4'd0;
   localparam logic [3:0] CHK_VX_OW  = 4'd1;
   localparam logic [3:0] CHK_AQ_EN  = 4'd2;
   localparam logic [3:0] CHK_AQ_DLY = 4'd3;
   localparam logic [3:0] CHK_BLKSZ  = 4'd4;
   localparam logic [3:0] CHK_AQ_DBG = 4'd5;
   localparam logic [3:0] CHK_AQ_CNT = 4'd6;
   localparam logic [3:0] CHK_AQ_SHF = 4'd7;

   typedef struct {
      int          test;
      op_e         op;
      logic [3:0]  addr;
      logic [23:0] data;
      logic [23:0] exp;
   } op_t;

   // Transfer waiting for its ack
   typedef struct {
      int         test;
      bit         rd;
      logic [3:0] addr;
      logic [7:0] exp;
   } xfer_t;

   logic                     clk_i;
   logic                     rst_i;
   logic                     cyc_i;
   logic                     stb_i;
   logic                     we_i;
   acq_bus_pkg::reg_addr_t   adr_i;
   acq_bus_pkg::bus_byte_t   dat_i;
   acq_bus_pkg::bus_byte_t   dat_o;
   logic                     ack_o;
   logic                     data_ready_i;
   logic                     data_request_o;
   acq_data_pkg::sample_t    data_in_i;
   logic                     spi_busy_i;
   logic                     overflow_i;
   logic                     streamed_i;
   logic                     vx_stuck_i;
   logic                     vx_limp_i;
   acq_data_pkg::blocksize_t blocksize_o;
   logic                     vx_enabled_o;
   logic                     vx_overwrite_o;
   logic                     aq_valid_i;
   logic [24:0]              aq_adr_i;
   logic                     aq_enabled_o;
   logic                     aq_debug_o;
   logic                     aq_shift_o;
   logic                     aq_count_o;
   acq_data_pkg::aq_delay_t  aq_delay_o;

   op_t         tbl[$];
   xfer_t       pend[$];
   int          errs[1:6];
   string       test_name[1:6];
   int          cycles = 0;
   int          limit = 100000;
   logic [31:0] rng = 32'h7c07;
   logic [23:0] mem_word = 24'h100001;
   int          mem_wait = 0;

   // Log block values and their block sizes, below, at and above saturation
   logic [4:0]  log_vals[5]  = '{5'd3, 5'd0, 5'd23, 5'd24, 5'd31};
   logic [23:0] log_sizes[5] = '{24'h000007, 24'h000000, 24'h7fffff,
                                 24'hffffff, 24'hffffff};

   acq_top i_acq_top (.*);

   // ------------------------------
   // Clock and timeout
   // ------------------------------
   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // Ends the run when the table takes far longer than planned
   always @(posedge clk_i) begin
      cycles++;
      if (cycles > limit) begin
         $display("Timeout: run passed %0d cycles without finishing", limit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // ------------------------------
   // Helpers
   // ------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [23:0] out_value(input logic [3:0] sel);
      case (sel)
         CHK_VX_EN:  return {23'd0, vx_enabled_o};
         CHK_VX_OW:  return {23'd0, vx_overwrite_o};
         CHK_AQ_EN:  return {23'd0, aq_enabled_o};
         CHK_AQ_DLY: return {21'd0, aq_delay_o};
         CHK_AQ_DBG: return {23'd0, aq_debug_o};
         CHK_AQ_CNT: return {23'd0, aq_count_o};
         CHK_AQ_SHF: return {23'd0, aq_shift_o};
         default:    return blocksize_o;
      endcase
   endfunction

   function automatic string out_name(input logic [3:0] sel);
      case (sel)
         CHK_VX_EN:  return "vx_enabled_o";
         CHK_VX_OW:  return "vx_overwrite_o";
         CHK_AQ_EN:  return "aq_enabled_o";
         CHK_AQ_DLY: return "aq_delay_o";
         CHK_AQ_DBG: return "aq_debug_o";
         CHK_AQ_CNT: return "aq_count_o";
         CHK_AQ_SHF: return "aq_shift_o";
         default:    return "blocksize_o";
      endcase
   endfunction

   task automatic add(input int t, input op_e op, input logic [3:0] addr,
                      input logic [23:0] data, input logic [23:0] exp);
      op_t e;
      e.test = t;
      e.op   = op;
      e.addr = addr;
      e.data = data;
      e.exp  = exp;
      tbl.push_back(e);
   endtask

   task automatic drive_idle();
      cyc_i      <= 1'b0;
      stb_i      <= 1'b0;
      we_i       <= 1'b0;
      overflow_i <= 1'b0;
      streamed_i <= 1'b0;
   endtask

   // Lets the last acks drain, then reports the test
   task automatic end_test(input int t);
      @(posedge clk_i);
      drive_idle();
      while (pend.size() > 0) begin
         @(negedge clk_i);
      end
      if (errs[t] == 0) begin
         $display("Test %0d (%s): pass", t, test_name[t]);
      end else begin
         $display("Test %0d (%s): fail, %0d errors", t, test_name[t], errs[t]);
      end
   endtask

   // ------------------------------
   // Memory source model
   // ------------------------------
   // Answers a request after 1 to 3 cycles with the next word
   always @(posedge clk_i) begin
      if (rst_i) begin
         data_ready_i <= 1'b0;
         mem_wait = 0;
      end else begin
         data_ready_i <= 1'b0;
         if (mem_wait > 0) begin
            mem_wait--;
            if (mem_wait == 0) begin
               data_ready_i <= 1'b1;
               data_in_i    <= mem_word;
               mem_word     = mem_word + 24'd1;
            end
         // A word in flight this cycle is not yet seen in the request
         end else if (data_request_o && !data_ready_i) begin
            rng = xorshift(rng);
            mem_wait = 1 + int'(rng % 32'd3);
         end
      end
   end

   // ------------------------------
   // Ack and read-data monitor
   // ------------------------------
   always @(negedge clk_i) begin
      xfer_t x;
      if (!rst_i && ack_o) begin
         assert (pend.size() > 0) else begin
            $display("Error at %0t ns: ack_o high with no transfer outstanding", $time);
            errs[6]++;
         end
         if (pend.size() > 0) begin
            x = pend.pop_front();
            if (x.rd) begin
               assert (dat_o === x.exp) else begin
                  $display("Mismatch at %0t ns: dat_o (reg %h) expected %h got %h",
                           $time, x.addr, x.exp, dat_o);
                  errs[x.test]++;
               end
            end
         end
      end
   end

   // ------------------------------
   // Stimulus table
   // ------------------------------
   initial begin
      int total;
      op_t e;
      xfer_t p;

      rst_i      = 1'b1;
      cyc_i      = 1'b0;
      stb_i      = 1'b0;
      we_i       = 1'b0;
      adr_i      = '0;
      dat_i      = '0;
      data_ready_i = 1'b0;
      data_in_i  = '0;
      spi_busy_i = 1'b1;
      overflow_i = 1'b0;
      streamed_i = 1'b0;
      vx_stuck_i = 1'b1;
      vx_limp_i  = 1'b0;
      aq_valid_i = 1'b1;
      aq_adr_i   = 25'h1_23a5;
      for (int i = 1; i <= 6; i++) begin
         errs[i] = 0;
      end
      test_name[1] = "acquisition registers";
      test_name[2] = "block size";
      test_name[3] = "overflow disable";
      test_name[4] = "bank counter";
      test_name[5] = "raw stream";
      test_name[6] = "back-to-back reads";

      // Extra bits of the system write are dropped
      add(1, OP_WR,  `ACQ_REG_AQ_SYSTEM, 24'hfd, 0);
      add(1, OP_WR,  `ACQ_REG_AQ_DEBUG,  24'h81, 0);
      add(1, OP_CHK, CHK_AQ_EN,  0, 24'd1);
      add(1, OP_CHK, CHK_AQ_DLY, 0, 24'd5);
      add(1, OP_CHK, CHK_AQ_DBG, 0, 24'd1);
      add(1, OP_CHK, CHK_AQ_CNT, 0, 24'd0);
      add(1, OP_CHK, CHK_AQ_SHF, 0, 24'd1);
      add(1, OP_RD,  `ACQ_REG_AQ_SYSTEM, 0, 24'hc5);
      add(1, OP_RD,  `ACQ_REG_AQ_DEBUG,  0, 24'hc1);
      // Every flag flipped to its other state
      add(1, OP_WR,  `ACQ_REG_AQ_SYSTEM, 24'h02, 0);
      add(1, OP_WR,  `ACQ_REG_AQ_DEBUG,  24'h02, 0);
      add(1, OP_CHK, CHK_AQ_EN,  0, 24'd0);
      add(1, OP_CHK, CHK_AQ_DLY, 0, 24'd2);
      add(1, OP_CHK, CHK_AQ_DBG, 0, 24'd0);
      add(1, OP_CHK, CHK_AQ_CNT, 0, 24'd1);
      add(1, OP_CHK, CHK_AQ_SHF, 0, 24'd0);
      add(1, OP_RD,  `ACQ_REG_AQ_SYSTEM, 0, 24'h42);
      add(1, OP_RD,  `ACQ_REG_AQ_DEBUG,  0, 24'h42);

      // Log values below, at and above the saturation point
      foreach (log_vals[i]) begin
         add(2, OP_WR,  `ACQ_REG_VX_SYSTEM, {19'd0, log_vals[i]}, 0);
         add(2, OP_CHK, CHK_BLKSZ, 0, log_sizes[i]);
         add(2, OP_RD,  `ACQ_REG_VX_SYSTEM, 0, {19'd0, log_vals[i]});
      end

      add(3, OP_WR,  `ACQ_REG_VX_SYSTEM, 24'h80, 0);
      add(3, OP_CHK, CHK_VX_EN, 0, 24'd1);
      add(3, OP_OVF, 0, 0, 0);
      add(3, OP_CHK, CHK_VX_EN, 0, 24'd0);
      add(3, OP_RD,  `ACQ_REG_VX_SYSTEM, 0, 24'h00);
      add(3, OP_WR,  `ACQ_REG_VX_SYSTEM, 24'hc0, 0);
      add(3, OP_CHK, CHK_VX_OW, 0, 24'd1);
      add(3, OP_OVF, 0, 0, 0);
      add(3, OP_CHK, CHK_VX_EN, 0, 24'd1);
      add(3, OP_RD,  `ACQ_REG_VX_SYSTEM, 0, 24'hc0);

      // Bank 14 plus three banks wraps to 1
      add(4, OP_WR,   `ACQ_REG_VX_STATUS, 24'hfe, 0);
      add(4, OP_RD,   `ACQ_REG_VX_STATUS, 0, 24'h0e);
      add(4, OP_STRM, 0, 0, 0);
      add(4, OP_STRM, 0, 0, 0);
      add(4, OP_STRM, 0, 0, 0);
      add(4, OP_RD,   `ACQ_REG_VX_STATUS, 0, 24'h01);

      // Both slots full after the wait, bytes MSB first
      add(5, OP_WAIT, 0, 24'd10, 0);
      add(5, OP_RD, `ACQ_REG_AX_STREAM, 0, 24'h10);
      add(5, OP_RD, `ACQ_REG_AX_STREAM, 0, 24'h00);
      add(5, OP_RD, `ACQ_REG_AX_STREAM, 0, 24'h01);
      add(5, OP_RD, `ACQ_REG_AX_DATA1,  0, 24'h10);
      add(5, OP_RD, `ACQ_REG_AX_DATA2,  0, 24'h00);
      add(5, OP_RD, `ACQ_REG_AX_DATA3,  0, 24'h02);
      add(5, OP_RD, `ACQ_REG_AX_STREAM, 0, 24'h10);
      add(5, OP_RD, `ACQ_REG_AX_STREAM, 0, 24'h00);
      add(5, OP_RD, `ACQ_REG_AX_STREAM, 0, 24'h02);

      // One transfer per cycle, a write followed at once by its read
      add(6, OP_WR, `ACQ_REG_AQ_DEBUG,  24'h00, 0);
      add(6, OP_RD, `ACQ_REG_AQ_DEBUG,  0, 24'h40);
      add(6, OP_RD, `ACQ_REG_AQ_STATUS, 0, 24'ha5);
      add(6, OP_RD, `ACQ_REG_VX_STREAM, 0, 24'h00);
      add(6, OP_RD, 4'h5,               0, 24'h00);
      add(6, OP_RD, `ACQ_REG_VX_STATUS, 0, 24'h01);
      add(6, OP_RD, `ACQ_REG_AQ_SYSTEM, 0, 24'h42);
      add(6, OP_RD, `ACQ_REG_VX_SYSTEM, 0, 24'hc0);

      limit = tbl.size() * 20;

      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;

      // ------------------------------
      // Apply the table
      // ------------------------------
      for (int i = 0; i < tbl.size(); i++) begin
         e = tbl[i];
         if (i > 0 && e.test != tbl[i-1].test) begin
            end_test(tbl[i-1].test);
         end
         @(posedge clk_i);
         drive_idle();
         case (e.op)
            OP_WR, OP_RD: begin
               cyc_i <= 1'b1;
               stb_i <= 1'b1;
               we_i  <= (e.op == OP_WR);
               adr_i <= e.addr;
               dat_i <= e.data[7:0];
               p.test = e.test;
               p.rd   = (e.op == OP_RD);
               p.addr = e.addr;
               p.exp  = e.exp[7:0];
               pend.push_back(p);
            end
            OP_OVF:  overflow_i <= 1'b1;
            OP_STRM: streamed_i <= 1'b1;
            OP_WAIT: begin
               repeat (e.data - 1) @(posedge clk_i);
            end
            default: begin
               // Outputs settle after the edge of the last write
               @(negedge clk_i);
               assert (out_value(e.addr) === e.exp) else begin
                  $display("Mismatch at %0t ns: %s expected %h got %h",
                           $time, out_name(e.addr), e.exp, out_value(e.addr));
                  errs[e.test]++;
               end
            end
         endcase
      end
      end_test(tbl[tbl.size()-1].test);

      total = 0;
      for (int i = 1; i <= 6; i++) begin
         total += errs[i];
      end
      $display("Checks done: %0d operations, %0d errors", tbl.size(), total);
      if (total == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: verification/acq_top_props.sv
`timescale 1ns/1ps

module acq_top_props (
   input logic clk_i,
   input logic rst_i,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_o,
   input logic data_request_o
);

   // ------------------------------
   // Bus timing
   // ------------------------------
   // Every strobed cycle is acknowledged on the next one
   ack_follows_xfer: assert property (
      @(posedge clk_i) disable iff (rst_i) (cyc_i && stb_i) |=> ack_o
   ) else $error("ack_o missing one cycle after a transfer");

   // No ack unless the cycle before carried a transfer
   ack_needs_xfer: assert property (
      @(posedge clk_i) disable iff (rst_i) ack_o |-> $past(cyc_i && stb_i)
   ) else $error("ack_o high without a transfer on the previous cycle");

   // Memory source stays idle while reset is applied
   no_request_in_reset: assert property (
      @(posedge clk_i) rst_i |=> !data_request_o
   ) else $error("data_request_o high during reset");

endmodule

bind acq_top acq_top_props i_acq_top_props (
   .clk_i          (clk_i),
   .rst_i          (rst_i),
   .cyc_i          (cyc_i),
   .stb_i          (stb_i),
   .ack_o          (ack_o),
   .data_request_o (data_request_o)
);

// File: verilog/acq_top.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module acq_top (
   input  logic                     clk_i,
   input  logic                     rst_i,
   // Host bus
   input  logic                     cyc_i,
   input  logic                     stb_i,
   input  logic                     we_i,
   input  acq_bus_pkg::reg_addr_t   adr_i,
   input  acq_bus_pkg::bus_byte_t   dat_i,
   output acq_bus_pkg::bus_byte_t   dat_o,
   output logic                     ack_o,
   // Raw sample memory source
   input  logic                     data_ready_i,
   output logic                     data_request_o,
   input  acq_data_pkg::sample_t    data_in_i,
   input  logic                     spi_busy_i,
   // Correlator
   input  logic                     overflow_i,
   input  logic                     streamed_i,
   input  logic                     vx_stuck_i,
   input  logic                     vx_limp_i,
   output acq_data_pkg::blocksize_t blocksize_o,
   output logic                     vx_enabled_o,
   output logic                     vx_overwrite_o,
   // Acquisition unit
   input  logic                     aq_valid_i,
   input  logic [24:0]              aq_adr_i,
   output logic                     aq_enabled_o,
   output logic                     aq_debug_o,
   output logic                     aq_shift_o,
   output logic                     aq_count_o,
   output acq_data_pkg::aq_delay_t  aq_delay_o
);

   // Decoded writes and stream reads
   acq_bus_pkg::bus_byte_t wr_data;
   logic                   aq_debug_wr;
   logic                   aq_system_wr;
   logic                   vx_status_wr;
   logic                   vx_system_wr;
   logic                   stream_rd;
   // Read-back bytes
   acq_bus_pkg::bus_byte_t aq_debug_byte;
   acq_bus_pkg::bus_byte_t aq_system_byte;
   acq_bus_pkg::bus_byte_t vx_status_byte;
   acq_bus_pkg::bus_byte_t vx_system_byte;
   acq_bus_pkg::bus_byte_t ax_stream;
   acq_data_pkg::sample_t  ax_word;

   // ------------------------------
   // Bus slave
   // ------------------------------
   // Status byte is the low byte of the capture address
   acq_bus_port i_acq_bus_port (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .cyc_i          (cyc_i),
      .stb_i          (stb_i),
      .we_i           (we_i),
      .adr_i          (adr_i),
      .dat_i          (dat_i),
      .ack_o          (ack_o),
      .dat_o          (dat_o),
      .aq_status_i    (aq_adr_i[7:0]),
      .aq_debug_i     (aq_debug_byte),
      .aq_system_i    (aq_system_byte),
      .vx_status_i    (vx_status_byte),
      .vx_system_i    (vx_system_byte),
      .ax_stream_i    (ax_stream),
      .ax_word_i      (ax_word),
      .wr_data_o      (wr_data),
      .aq_debug_wr_o  (aq_debug_wr),
      .aq_system_wr_o (aq_system_wr),
      .vx_status_wr_o (vx_status_wr),
      .vx_system_wr_o (vx_system_wr),
      .stream_rd_o    (stream_rd)
   );

   // ------------------------------
   // Register blocks
   // ------------------------------
   acq_ctrl_regs i_acq_ctrl_regs (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .wr_data_i        (wr_data),
      .aq_debug_wr_i    (aq_debug_wr),
      .aq_system_wr_i   (aq_system_wr),
      .aq_valid_i       (aq_valid_i),
      .vx_stuck_i       (vx_stuck_i),
      .vx_limp_i        (vx_limp_i),
      .aq_enabled_o     (aq_enabled_o),
      .aq_debug_o       (aq_debug_o),
      .aq_shift_o       (aq_shift_o),
      .aq_count_o       (aq_count_o),
      .aq_delay_o       (aq_delay_o),
      .aq_debug_byte_o  (aq_debug_byte),
      .aq_system_byte_o (aq_system_byte)
   );

   viz_ctrl i_viz_ctrl (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .wr_data_i        (wr_data),
      .vx_status_wr_i   (vx_status_wr),
      .vx_system_wr_i   (vx_system_wr),
      .overflow_i       (overflow_i),
      .streamed_i       (streamed_i),
      .vx_enabled_o     (vx_enabled_o),
      .vx_overwrite_o   (vx_overwrite_o),
      .blocksize_o      (blocksize_o),
      .vx_status_byte_o (vx_status_byte),
      .vx_system_byte_o (vx_system_byte)
   );

   // Antenna sample prefetch for the stream registers
   raw_prefetch i_raw_prefetch (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .data_ready_i   (data_ready_i),
      .data_in_i      (data_in_i),
      .data_request_o (data_request_o),
      .stream_rd_i    (stream_rd),
      .spi_busy_i     (spi_busy_i),
      .ax_word_o      (ax_word),
      .ax_stream_o    (ax_stream)
   );

endmodule

// File: verilog/raw_prefetch.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module raw_prefetch (
   input  logic                   clk_i,
   input  logic                   rst_i,
   // Memory source
   input  logic                   data_ready_i,
   input  acq_data_pkg::sample_t  data_in_i,
   output logic                   data_request_o,
   // Host side
   input  logic                   stream_rd_i,
   input  logic                   spi_busy_i,
   output acq_data_pkg::sample_t  ax_word_o,
   output acq_bus_pkg::bus_byte_t ax_stream_o
);

   acq_data_pkg::pf_state_t state;
   acq_data_pkg::pf_state_t state_nxt;
   acq_data_pkg::sample_t   next_word;
   acq_data_pkg::byte_sel_t idx;
   logic                    wrap;

   // Last byte of the current word is being read
   assign wrap = stream_rd_i && spi_busy_i && (idx == 2'd2);

   // ------------------------------
   // Slot FSM
   // ------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         acq_data_pkg::PF_EMPTY: if (data_ready_i) state_nxt = acq_data_pkg::PF_ONE;
         // A fill during a wrap goes straight to the current slot
         acq_data_pkg::PF_ONE:   if (data_ready_i && !wrap) state_nxt = acq_data_pkg::PF_FULL;
         acq_data_pkg::PF_FULL:  if (wrap && !data_ready_i) state_nxt = acq_data_pkg::PF_ONE;
         default:                state_nxt = acq_data_pkg::PF_EMPTY;
      endcase
   end

   // Request tracks the next state so it drops as the last slot fills
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state          <= acq_data_pkg::PF_EMPTY;
         data_request_o <= 1'b0;
      end else begin
         state          <= state_nxt;
         data_request_o <= (state_nxt != acq_data_pkg::PF_FULL);
      end
   end

   // Word slots, current word held on a wrap with no next word
   always_ff @(posedge clk_i) begin
      if (state == acq_data_pkg::PF_FULL) begin
         if (wrap) ax_word_o <= next_word;
         if (wrap && data_ready_i) next_word <= data_in_i;
      end else if (data_ready_i) begin
         if (state == acq_data_pkg::PF_EMPTY || wrap) ax_word_o <= data_in_i;
         else next_word <= data_in_i;
      end
   end

   // ------------------------------
   // Stream byte index
   // ------------------------------
   // Back to the first byte whenever SPI goes idle
   always_ff @(posedge clk_i) begin
      if (rst_i || !spi_busy_i) begin
         idx <= '0;
      end else if (stream_rd_i) begin
         idx <= wrap ? 2'd0 : idx + 2'd1;
      end
   end

   // MSB first
   always_comb begin
      case (idx)
         2'd0:    ax_stream_o = ax_word_o[23:16];
         2'd1:    ax_stream_o = ax_word_o[15:8];
         default: ax_stream_o = ax_word_o[7:0];
      endcase
   end

endmodule

// File: verilog/viz_ctrl.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module viz_ctrl (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  acq_bus_pkg::bus_byte_t   wr_data_i,
   input  logic                     vx_status_wr_i,
   input  logic                     vx_system_wr_i,
   // Correlator events
   input  logic                     overflow_i,
   input  logic                     streamed_i,
   // Correlator settings
   output logic                     vx_enabled_o,
   output logic                     vx_overwrite_o,
   output acq_data_pkg::blocksize_t blocksize_o,
   // Packed read bytes
   output acq_bus_pkg::bus_byte_t   vx_status_byte_o,
   output acq_bus_pkg::bus_byte_t   vx_system_byte_o
);

   acq_data_pkg::log_block_t log_block;
   acq_data_pkg::log_block_t new_log;
   acq_data_pkg::blocksize_t new_size;
   acq_data_pkg::blk_idx_t   bank;

   // ------------------------------
   // Block size from log2 value
   // ------------------------------
   assign new_log = wr_data_i[4:0];

   // Saturate once the shift would leave the counter width
   always_comb begin
      if (new_log >= acq_data_pkg::log_block_t'(`ACQ_ACCUM_W)) begin
         new_size = '1;
      end else begin
         new_size = (acq_data_pkg::blocksize_t'(1) << new_log)
                    - acq_data_pkg::blocksize_t'(1);
      end
   end

   // Control register and derived block size
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         vx_enabled_o   <= 1'b0;
         vx_overwrite_o <= 1'b0;
         log_block      <= '0;
         blocksize_o    <= '0;
      end else begin
         if (vx_system_wr_i) begin
            vx_overwrite_o <= wr_data_i[6];
            log_block      <= new_log;
            blocksize_o    <= new_size;
         end
         // Overflow stops the correlator unless overwriting is allowed
         if (overflow_i && !vx_overwrite_o) begin
            vx_enabled_o <= 1'b0;
         end else if (vx_system_wr_i) begin
            vx_enabled_o <= wr_data_i[7];
         end
      end
   end

   // ------------------------------
   // Bank counter
   // ------------------------------
   // Host write wins over a streamed bank
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bank <= '0;
      end else if (vx_status_wr_i) begin
         bank <= wr_data_i[3:0];
      end else if (streamed_i) begin
         bank <= bank + acq_data_pkg::blk_idx_t'(1);
      end
   end

   assign vx_status_byte_o = {2'b00, overflow_i, 1'b0, bank};
   assign vx_system_byte_o = {vx_enabled_o, vx_overwrite_o, 1'b0, log_block};

endmodule

// File: verilog/acq_ctrl_regs.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module acq_ctrl_regs (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  acq_bus_pkg::bus_byte_t  wr_data_i,
   input  logic                    aq_debug_wr_i,
   input  logic                    aq_system_wr_i,
   // Status inputs, read back only
   input  logic                    aq_valid_i,
   input  logic                    vx_stuck_i,
   input  logic                    vx_limp_i,
   // Acquisition settings
   output logic                    aq_enabled_o,
   output logic                    aq_debug_o,
   output logic                    aq_shift_o,
   output logic                    aq_count_o,
   output acq_data_pkg::aq_delay_t aq_delay_o,
   // Packed read bytes
   output acq_bus_pkg::bus_byte_t  aq_debug_byte_o,
   output acq_bus_pkg::bus_byte_t  aq_system_byte_o
);

   // ------------------------------
   // Register writes
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         aq_enabled_o <= 1'b0;
         aq_delay_o   <= '0;
         aq_debug_o   <= 1'b0;
         aq_shift_o   <= 1'b0;
         aq_count_o   <= 1'b0;
      end else begin
         // Control: enable on bit 7, delay in the low bits
         if (aq_system_wr_i) begin
            aq_enabled_o <= wr_data_i[7];
            aq_delay_o   <= wr_data_i[2:0];
         end
         // Debug flags
         if (aq_debug_wr_i) begin
            aq_debug_o <= wr_data_i[7];
            aq_count_o <= wr_data_i[1];
            aq_shift_o <= wr_data_i[0];
         end
      end
   end

   // Correlator health sits next to the debug flag
   assign aq_debug_byte_o  = {aq_debug_o, vx_stuck_i, vx_limp_i, 3'b000,
                              aq_count_o, aq_shift_o};
   // Valid comes straight from the acquisition unit
   assign aq_system_byte_o = {aq_enabled_o, aq_valid_i, 3'b000, aq_delay_o};

endmodule

// File: verilog/acq_bus_port.sv
`timescale 1ns/1ps
`include "acq_params.svh"

module acq_bus_port (
   input  logic                  clk_i,
   input  logic                  rst_i,
   // Host bus
   input  logic                  cyc_i,
   input  logic                  stb_i,
   input  logic                  we_i,
   input  acq_bus_pkg::reg_addr_t adr_i,
   input  acq_bus_pkg::bus_byte_t dat_i,
   output logic                  ack_o,
   output acq_bus_pkg::bus_byte_t dat_o,
   // Read bytes from the register blocks
   input  acq_bus_pkg::bus_byte_t aq_status_i,
   input  acq_bus_pkg::bus_byte_t aq_debug_i,
   input  acq_bus_pkg::bus_byte_t aq_system_i,
   input  acq_bus_pkg::bus_byte_t vx_status_i,
   input  acq_bus_pkg::bus_byte_t vx_system_i,
   input  acq_bus_pkg::bus_byte_t ax_stream_i,
   input  acq_data_pkg::sample_t  ax_word_i,
   // Write strobes, valid for the transfer cycle only
   output acq_bus_pkg::bus_byte_t wr_data_o,
   output logic                  aq_debug_wr_o,
   output logic                  aq_system_wr_o,
   output logic                  vx_status_wr_o,
   output logic                  vx_system_wr_o,
   output logic                  stream_rd_o
);

   logic                   xfer;
   acq_bus_pkg::bus_byte_t rd_byte;

   // Pipelined bus, one transfer per strobed cycle
   assign xfer = cyc_i && stb_i;

   // ------------------------------
   // Address decode
   // ------------------------------
   assign wr_data_o      = dat_i;
   assign aq_debug_wr_o  = xfer && we_i && (adr_i == `ACQ_REG_AQ_DEBUG);
   assign aq_system_wr_o = xfer && we_i && (adr_i == `ACQ_REG_AQ_SYSTEM);
   assign vx_status_wr_o = xfer && we_i && (adr_i == `ACQ_REG_VX_STATUS);
   assign vx_system_wr_o = xfer && we_i && (adr_i == `ACQ_REG_VX_SYSTEM);
   // Advances the stream byte index
   assign stream_rd_o    = xfer && !we_i && (adr_i == `ACQ_REG_AX_STREAM);

   // Read multiplexer
   always_comb begin
      case (adr_i)
         `ACQ_REG_AX_STREAM: rd_byte = ax_stream_i;
         `ACQ_REG_AX_DATA1:  rd_byte = ax_word_i[23:16];
         `ACQ_REG_AX_DATA2:  rd_byte = ax_word_i[15:8];
         `ACQ_REG_AX_DATA3:  rd_byte = ax_word_i[7:0];
         `ACQ_REG_AQ_STATUS: rd_byte = aq_status_i;
         `ACQ_REG_AQ_DEBUG:  rd_byte = aq_debug_i;
         `ACQ_REG_AQ_SYSTEM: rd_byte = aq_system_i;
         `ACQ_REG_VX_STATUS: rd_byte = vx_status_i;
         `ACQ_REG_VX_SYSTEM: rd_byte = vx_system_i;
         // VX_STREAM and the gaps in the map read as zero
         default:            rd_byte = '0;
      endcase
   end

   // ------------------------------
   // Acknowledge and read data
   // ------------------------------
   // Ack one cycle after every transfer
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= xfer;
      end
   end

   // Read byte captured alongside the ack
   always_ff @(posedge clk_i) begin
      if (xfer && !we_i) begin
         dat_o <= rd_byte;
      end
   end

endmodule

// File: verilog/acq_data_pkg.sv
`include "acq_params.svh"

// Types for antenna samples, visibilities blocks and the prefetcher
package acq_data_pkg;

   // Raw antenna sample as fetched from memory
   typedef logic [`ACQ_SAMPLE_W-1:0] sample_t;

   // Visibilities bank counter
   typedef logic [`ACQ_BLK_W-1:0] blk_idx_t;
   // Visibilities per block, minus one
   typedef logic [`ACQ_ACCUM_W-1:0] blocksize_t;
   // log2 of the block size, as written by the host
   typedef logic [4:0] log_block_t;

   // Acquisition sample delay
   typedef logic [2:0] aq_delay_t;
   // Next byte of the stream register, MSB first
   typedef logic [1:0] byte_sel_t;

   // Prefetcher fill level: no word, current only, current and next
   typedef enum logic [1:0] {
      PF_EMPTY,
      PF_ONE,
      PF_FULL
   } pf_state_t;

endpackage

// File: verilog/acq_bus_pkg.sv
`include "acq_params.svh"

// Types for the byte-wide host bus
package acq_bus_pkg;

   // ------------------------------
   // Bus payload
   // ------------------------------
   // One byte on the host data lines, both directions
   typedef logic [`ACQ_BUS_W-1:0] bus_byte_t;

   // ------------------------------
   // Register map
   // ------------------------------
   // Register address, decoded against the ACQ_REG_* values
   typedef logic [`ACQ_ADDR_W-1:0] reg_addr_t;

endpackage

// File: verilog/acq_params.svh
`ifndef ACQ_PARAMS_SVH
`define ACQ_PARAMS_SVH

// ------------------------------
// Widths
// ------------------------------
// Host bus data byte and register address
`define ACQ_BUS_W    8
`define ACQ_ADDR_W   4
// One raw antenna sample, three bus bytes wide
`define ACQ_SAMPLE_W 24
// Visibilities bank index and block-size counter
`define ACQ_BLK_W    4
`define ACQ_ACCUM_W  24

// ------------------------------
// Register map
// ------------------------------
// Raw antenna-data read-back
`define ACQ_REG_AX_STREAM 4'h0
`define ACQ_REG_AX_DATA1  4'h1
`define ACQ_REG_AX_DATA2  4'h2
`define ACQ_REG_AX_DATA3  4'h3
// Acquisition status and control
`define ACQ_REG_AQ_STATUS 4'h4
`define ACQ_REG_AQ_DEBUG  4'h6
`define ACQ_REG_AQ_SYSTEM 4'h7
// Visibilities stream, status and control
`define ACQ_REG_VX_STREAM 4'h8
`define ACQ_REG_VX_STATUS 4'h9
`define ACQ_REG_VX_SYSTEM 4'ha

`endif
